// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mips_isa_pkg.sv
      - common/pipe_ctrl_pkg.sv
      - src/decode/ctrl_decoder.sv
      - src/hazard/tnew_tracker.sv
      - src/hazard/stall_unit.sv
      - src/decode_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_decode_stage.sv

// File: common/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// opcode field
`define MIPS_OPC_HI 31
`define MIPS_OPC_LO 26

// function code of special instructions
`define MIPS_FUNCT_HI 5
`define MIPS_FUNCT_LO 0

// register fields
`define MIPS_RS_HI 25
`define MIPS_RS_LO 21
`define MIPS_RT_HI 20
`define MIPS_RT_LO 16
`define MIPS_RD_HI 15
`define MIPS_RD_LO 11

// register address width
`define MIPS_REG_W 5

// tuse width and the value for an operand that is never read
`define MIPS_TUSE_W 5
`define MIPS_TUSE_NONE 5'd16

// link register for jal and bltzal
`define MIPS_RA 5'd31

`endif

// File: common/mips_isa_pkg.sv
`include "mips_defines.svh"

package mips_isa_pkg;

    // primary opcodes known to the decoder
    typedef enum logic [`MIPS_OPC_HI-`MIPS_OPC_LO:0] {
        // r-type with the real op in funct
        OPC_SPECIAL = 6'b000000,
        OPC_J       = 6'b000010,
        OPC_JAL     = 6'b000011,
        OPC_BEQ     = 6'b000100,
        OPC_ORI     = 6'b001101,
        OPC_LUI     = 6'b001111,
        OPC_LW      = 6'b100011,
        // branch if rs < 0 and link
        OPC_BLTZAL  = 6'b100111,
        OPC_SW      = 6'b101011
    } opcode_e;

    // function codes under OPC_SPECIAL
    typedef enum logic [`MIPS_FUNCT_HI-`MIPS_FUNCT_LO:0] {
        // shift by shamt reading rt only
        FN_SLL  = 6'b000000,
        FN_JR   = 6'b001000,
        FN_ADD  = 6'b100000,
        // unsigned forms behave the same here
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011
    } funct_e;

endpackage

// File: common/pipe_ctrl_pkg.sv
`include "mips_defines.svh"

package pipe_ctrl_pkg;

    // execute stage operation
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2,
        ALU_SLL = 2'd3
    } alu_op_e;

    // second alu operand
    typedef enum logic {
        SRC_RT  = 1'b0,
        SRC_IMM = 1'b1
    } alu_src_e;

    // immediate extension
    typedef enum logic [1:0] {
        EXT_ZERO = 2'd0,
        EXT_SIGN = 2'd1,
        // imm16 into upper half
        EXT_HIGH = 2'd2
    } ext_op_e;

    // next pc source
    typedef enum logic [1:0] {
        NPC_SEQ    = 2'd0,
        NPC_BRANCH = 2'd1,
        NPC_REG    = 2'd2,
        NPC_JUMP   = 2'd3
    } npc_sel_e;

    // branch condition
    typedef enum logic [1:0] {
        BRC_EQ     = 2'd0,
        BRC_ALWAYS = 2'd1,
        BRC_LTZ    = 2'd2
    } brc_op_e;

    // writeback data source
    typedef enum logic [1:0] {
        WB_ALU    = 2'd0,
        WB_MEM    = 2'd1,
        WB_IMM_HI = 2'd2,
        WB_PC8    = 2'd3
    } wb_src_e;

    // operand source for a decoded register
    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_E  = 2'd1,
        FWD_M  = 2'd2,
        FWD_W  = 2'd3
    } fwd_sel_e;

    // control word handed down the pipe
    typedef struct packed {
        npc_sel_e npc_sel;
        brc_op_e  brc_op;
        ext_op_e  ext_op;
        alu_op_e  alu_op;
        // shift amount from shamt field
        logic     alu_shift;
        alu_src_e alu_src;
        logic     mem_we;
        logic     reg_we;
        wb_src_e  wb_src;
    } ctrl_word_t;

    // in-flight result tag
    typedef struct packed {
        logic                   valid;
        logic [`MIPS_REG_W-1:0] dst;
        // cycles until the result can be forwarded
        logic [1:0]             tnew;
    } hazard_tag_t;

    // source registers and the latest cycle each is needed
    typedef struct packed {
        logic [`MIPS_REG_W-1:0]  rs;
        logic [`MIPS_REG_W-1:0]  rt;
        logic [`MIPS_TUSE_W-1:0] tuse_rs;
        logic [`MIPS_TUSE_W-1:0] tuse_rt;
    } src_req_t;

endpackage

// File: project.f
+incdir+common
common/mips_isa_pkg.sv
common/pipe_ctrl_pkg.sv
src/decode/ctrl_decoder.sv
src/hazard/tnew_tracker.sv
src/hazard/stall_unit.sv
src/decode_stage.sv
testbench/tb_decode_stage.sv

// File: src/decode/ctrl_decoder.sv
`timescale 1ns/10ps
`include "mips_defines.svh"

module ctrl_decoder
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic [31:0] instr,
    output ctrl_word_t  ctrl,
    output src_req_t    req,
    output hazard_tag_t new_tag
);

    opcode_e                opc;
    funct_e                 fn;
    logic [`MIPS_REG_W-1:0] rs;
    logic [`MIPS_REG_W-1:0] rt;
    logic [`MIPS_REG_W-1:0] rd;
    logic [`MIPS_REG_W-1:0] dst;
    logic [1:0]             tnew;

    // field split
    assign opc = opcode_e'(instr[`MIPS_OPC_HI:`MIPS_OPC_LO]);
    assign fn  = funct_e'(instr[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO]);
    assign rs  = instr[`MIPS_RS_HI:`MIPS_RS_LO];
    assign rt  = instr[`MIPS_RT_HI:`MIPS_RT_LO];
    assign rd  = instr[`MIPS_RD_HI:`MIPS_RD_LO];

    always_comb begin
        // defaults give a no-op
        ctrl.npc_sel   = NPC_SEQ;
        ctrl.brc_op    = BRC_EQ;
        ctrl.ext_op    = EXT_ZERO;
        ctrl.alu_op    = ALU_ADD;
        ctrl.alu_shift = 1'b0;
        ctrl.alu_src   = SRC_RT;
        ctrl.mem_we    = 1'b0;
        ctrl.reg_we    = 1'b0;
        ctrl.wb_src    = WB_ALU;
        dst            = '0;
        tnew           = 2'd0;
        req.rs         = rs;
        req.rt         = rt;
        req.tuse_rs    = `MIPS_TUSE_NONE;
        req.tuse_rt    = `MIPS_TUSE_NONE;

        case (opc)
            OPC_SPECIAL: begin
                case (fn)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: begin
                        ctrl.alu_op = (fn == FN_SUB || fn == FN_SUBU) ? ALU_SUB : ALU_ADD;
                        ctrl.reg_we = 1'b1;
                        dst         = rd;
                        // alu result after E
                        tnew        = 2'd1;
                        req.tuse_rs = 5'd1;
                        req.tuse_rt = 5'd1;
                    end
                    FN_SLL: begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.alu_shift = 1'b1;
                        ctrl.reg_we    = 1'b1;
                        dst            = rd;
                        tnew           = 2'd1;
                        // rs field unused by shifts
                        req.tuse_rt    = 5'd1;
                    end
                    FN_JR: begin
                        ctrl.npc_sel = NPC_REG;
                        ctrl.brc_op  = BRC_ALWAYS;
                        // target needed in decode
                        req.tuse_rs  = 5'd0;
                    end
                    default: ;
                endcase
            end
            OPC_ORI: begin
                ctrl.alu_op  = ALU_OR;
                ctrl.alu_src = SRC_IMM;
                ctrl.reg_we  = 1'b1;
                dst          = rt;
                tnew         = 2'd1;
                req.tuse_rs  = 5'd1;
            end
            OPC_LUI: begin
                ctrl.ext_op = EXT_HIGH;
                ctrl.reg_we = 1'b1;
                ctrl.wb_src = WB_IMM_HI;
                dst         = rt;
                // value known at decode
                tnew        = 2'd0;
            end
            OPC_LW: begin
                ctrl.ext_op  = EXT_SIGN;
                ctrl.alu_src = SRC_IMM;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_src  = WB_MEM;
                dst          = rt;
                // data only after M
                tnew         = 2'd2;
                req.tuse_rs  = 5'd1;
            end
            OPC_SW: begin
                ctrl.ext_op  = EXT_SIGN;
                ctrl.alu_src = SRC_IMM;
                ctrl.mem_we  = 1'b1;
                req.tuse_rs  = 5'd1;
                // store data read late in M
                req.tuse_rt  = 5'd2;
            end
            OPC_BEQ: begin
                ctrl.npc_sel = NPC_BRANCH;
                ctrl.ext_op  = EXT_SIGN;
                req.tuse_rs  = 5'd0;
                req.tuse_rt  = 5'd0;
            end
            OPC_J: begin
                ctrl.npc_sel = NPC_JUMP;
                ctrl.brc_op  = BRC_ALWAYS;
            end
            OPC_JAL: begin
                ctrl.npc_sel = NPC_JUMP;
                ctrl.brc_op  = BRC_ALWAYS;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_src  = WB_PC8;
                dst          = `MIPS_RA;
            end
            OPC_BLTZAL: begin
                ctrl.npc_sel = NPC_BRANCH;
                ctrl.brc_op  = BRC_LTZ;
                ctrl.ext_op  = EXT_SIGN;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_src  = WB_PC8;
                dst          = `MIPS_RA;
                // sign of rs checked in decode
                req.tuse_rs  = 5'd0;
            end
            default: ;
        endcase

        // writes to $zero never produce a tag
        new_tag.valid = ctrl.reg_we && (dst != '0);
        new_tag.dst   = dst;
        new_tag.tnew  = tnew;
    end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps
`include "mips_defines.svh"

module decode_stage
    import pipe_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    output ctrl_word_t             ctrl,
    output logic                   issue,
    output logic                   stall,
    output fwd_sel_e               fwd_rs,
    output fwd_sel_e               fwd_rt,
    output logic [`MIPS_REG_W-1:0] dst,
    output logic [1:0]             tnew
);

    src_req_t    req;
    hazard_tag_t new_tag;
    hazard_tag_t slot_e;
    hazard_tag_t slot_m;
    hazard_tag_t slot_w;

    // pure decode of the presented word
    ctrl_decoder i_ctrl_decoder (
        .instr   (instr),
        .ctrl    (ctrl),
        .req     (req),
        .new_tag (new_tag)
    );

    // hazard check against results in flight
    stall_unit i_stall_unit (
        .instr_valid (instr_valid),
        .req         (req),
        .slot_e      (slot_e),
        .slot_m      (slot_m),
        .slot_w      (slot_w),
        .stall       (stall),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt)
    );

    // accepted when presented and not interlocked
    assign issue = instr_valid && !stall;

    tnew_tracker i_tnew_tracker (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .new_tag (new_tag),
        .slot_e  (slot_e),
        .slot_m  (slot_m),
        .slot_w  (slot_w)
    );

    // tag that travels with ctrl into E
    // dst 0 marks no register write
    assign dst  = new_tag.valid ? new_tag.dst : '0;
    assign tnew = new_tag.tnew;

endmodule

// File: src/hazard/stall_unit.sv
`timescale 1ns/10ps
`include "mips_defines.svh"

module stall_unit
    import pipe_ctrl_pkg::*;
(
    input  logic        instr_valid,
    input  src_req_t    req,
    input  hazard_tag_t slot_e,
    input  hazard_tag_t slot_m,
    input  hazard_tag_t slot_w,
    output logic        stall,
    output fwd_sel_e    fwd_rs,
    output fwd_sel_e    fwd_rt
);

    logic stall_rs;
    logic stall_rt;

    // register matches a live result
    function automatic logic hit(input logic [`MIPS_REG_W-1:0] r, input hazard_tag_t s);
        return s.valid && (r != '0) && (s.dst == r);
    endfunction

    // result from this slot arrives too late
    function automatic logic late(
        input logic [`MIPS_REG_W-1:0]  r,
        input logic [`MIPS_TUSE_W-1:0] tuse,
        input hazard_tag_t             s
    );
        logic [`MIPS_TUSE_W-1:0] tnew_ext;
        tnew_ext = {3'b000, s.tnew};
        return hit(r, s) && (tuse != `MIPS_TUSE_NONE) && (tnew_ext > tuse);
    endfunction

    // youngest matching stage wins
    function automatic fwd_sel_e pick(
        input logic [`MIPS_REG_W-1:0] r,
        input hazard_tag_t            e,
        input hazard_tag_t            m,
        input hazard_tag_t            w
    );
        if (hit(r, e)) begin
            return FWD_E;
        end else if (hit(r, m)) begin
            return FWD_M;
        end else if (hit(r, w)) begin
            return FWD_W;
        end
        return FWD_RF;
    endfunction

    // any in-flight writer can block a source
    assign stall_rs = late(req.rs, req.tuse_rs, slot_e) ||
                      late(req.rs, req.tuse_rs, slot_m) ||
                      late(req.rs, req.tuse_rs, slot_w);
    assign stall_rt = late(req.rt, req.tuse_rt, slot_e) ||
                      late(req.rt, req.tuse_rt, slot_m) ||
                      late(req.rt, req.tuse_rt, slot_w);

    assign stall = instr_valid && (stall_rs || stall_rt);

    assign fwd_rs = pick(req.rs, slot_e, slot_m, slot_w);
    assign fwd_rt = pick(req.rt, slot_e, slot_m, slot_w);

endmodule

// File: src/hazard/tnew_tracker.sv
`timescale 1ns/10ps
`include "mips_defines.svh"

module tnew_tracker
    import pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        issue,
    input  hazard_tag_t new_tag,
    output hazard_tag_t slot_e,
    output hazard_tag_t slot_m,
    output hazard_tag_t slot_w
);

    // age by one stage
    // tnew saturates at 0
    function automatic hazard_tag_t age(input hazard_tag_t t);
        hazard_tag_t aged;
        aged = t;
        if (t.tnew != 2'd0) begin
            aged.tnew = t.tnew - 2'd1;
        end
        return aged;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_e <= '0;
            slot_m <= '0;
            slot_w <= '0;
        end else begin
            // shift toward W
            slot_w <= age(slot_m);
            slot_m <= age(slot_e);
            // bubble when nothing issues
            slot_e <= issue ? new_tag : '0;
        end
    end

    // decoder only hands out tnew 0..2
    a_tnew_range: assert property (
        @(posedge clk) disable iff (reset)
        (issue && new_tag.valid) |-> (new_tag.tnew <= 2'd2)
    );

    // a tag for $zero must never reach the pipe
    a_no_zero_dst: assert property (
        @(posedge clk) disable iff (reset)
        (issue && new_tag.valid) |-> (new_tag.dst != '0)
    );

endmodule

// File: testbench/tb_decode_stage.sv
`timescale 1ns/10ps
`include "mips_defines.svh"

module tb_decode_stage
    import mips_isa_pkg::*;
    import pipe_ctrl_pkg::*;
;

    localparam int CLK_PERIOD  = 100;
    localparam int RESET_TICKS = 16;

    // one table row
    // row name sits in a parallel queue
    typedef struct packed {
        logic                   valid;
        logic [31:0]            word;
        logic                   stall;
        fwd_sel_e               fwd_rs;
        fwd_sel_e               fwd_rt;
        alu_op_e                alu_op;
        logic                   mem_we;
        logic                   reg_we;
        wb_src_e                wb_src;
        logic [`MIPS_REG_W-1:0] dst;
        logic [1:0]             tnew;
    } row_t;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [31:0]            instr;
    ctrl_word_t             ctrl;
    logic                   issue;
    logic                   stall;
    fwd_sel_e               fwd_rs;
    fwd_sel_e               fwd_rt;
    logic [`MIPS_REG_W-1:0] dst;
    logic [1:0]             tnew;

    row_t  rows[$];
    string row_names[$];
    int    cycle_count   = 0;
    int    timeout_limit = 40;
    int    error_count   = 0;

    decode_stage i_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .issue       (issue),
        .stall       (stall),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt),
        .dst         (dst),
        .tnew        (tnew)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // r-type word
    function automatic logic [31:0] enc_r(logic [5:0] fn, int rs, int rt, int rd, int shamt);
        return {6'b000000, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
    endfunction

    // i-type word
    function automatic logic [31:0] enc_i(logic [5:0] opc, int rs, int rt, int imm);
        return {opc, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // j-type word
    function automatic logic [31:0] enc_j(logic [5:0] opc, int target);
        return {opc, target[25:0]};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic stl,
                           input fwd_sel_e f_rs, input fwd_sel_e f_rt, input alu_op_e alu,
                           input logic mem_we, input logic reg_we, input wb_src_e wb);
        row_t r;
        r = '{1'b1, word, stl, f_rs, f_rt, alu, mem_we, reg_we, wb, 5'd0, 2'd0};
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // issued tag expected with the last added row
    task automatic expect_tag(input int d, input int t);
        row_t r;
        r      = rows.pop_back();
        r.dst  = d[`MIPS_REG_W-1:0];
        r.tnew = t[1:0];
        rows.push_back(r);
    endtask

    // nothing presented this cycle
    task automatic add_idle(input string name);
        row_t r;
        r = '{1'b0, 32'h0, 1'b0, FWD_RF, FWD_RF, ALU_ADD, 1'b0, 1'b0, WB_ALU, 5'd0, 2'd0};
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    task automatic stop_with_failure(input string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        error_count++;
        $display("[FAIL] %s %s expected %0d actual %0d", name, field, expected, actual);
        stop_with_failure("output mismatch");
    endtask

    task automatic build_table();
        // slots empty after reset so any reads are safe
        add_row("first_add", enc_r(FN_ADD, 1, 2, 3, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(3, 1);
        // $3 ages E then M then W
        add_row("fwd_e", enc_r(FN_ADD, 3, 0, 4, 0), 0, FWD_E, FWD_RF, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(4, 1);
        add_row("fwd_m", enc_r(FN_SUB, 0, 3, 5, 0), 0, FWD_RF, FWD_M, ALU_SUB, 0, 1, WB_ALU);
        expect_tag(5, 1);
        add_row("fwd_w", enc_r(FN_ADDU, 3, 4, 6, 0), 0, FWD_W, FWD_M, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(6, 1);
        add_idle("idle_gap");
        // load then dependent alu op costs one bubble
        add_row("lw", enc_i(OPC_LW, 1, 7, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_MEM);
        expect_tag(7, 2);
        add_row("load_use", enc_r(FN_ADD, 7, 6, 8, 0), 1, FWD_E, FWD_W, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(8, 1);
        add_row("load_use_go", enc_r(FN_ADD, 7, 6, 8, 0), 0, FWD_M, FWD_RF, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(8, 1);
        // branch compares in decode with tuse 0
        add_row("beq_early", enc_i(OPC_BEQ, 8, 0, 4), 1, FWD_E, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("beq_go", enc_i(OPC_BEQ, 8, 0, 4), 0, FWD_M, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        // link value is ready at once
        add_row("jal", enc_j(OPC_JAL, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_PC8);
        expect_tag(31, 0);
        add_row("jr_ra", enc_r(FN_JR, 31, 0, 0, 0), 0, FWD_E, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("ori", enc_i(OPC_ORI, 0, 9, 5), 0, FWD_RF, FWD_RF, ALU_OR, 0, 1, WB_ALU);
        expect_tag(9, 1);
        add_row("jr_early", enc_r(FN_JR, 9, 0, 0, 0), 1, FWD_E, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("jr_go", enc_r(FN_JR, 9, 0, 0, 0), 0, FWD_M, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        // store data tuse 2 meets load tnew 2
        add_row("lw_data", enc_i(OPC_LW, 2, 10, 4), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_MEM);
        expect_tag(10, 2);
        add_row("sw_data", enc_i(OPC_SW, 2, 10, 8), 0, FWD_RF, FWD_E, ALU_ADD, 1, 0, WB_ALU);
        add_row("lui", enc_i(OPC_LUI, 0, 11, 'h1234), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_IMM_HI);
        expect_tag(11, 0);
        add_row("sll", enc_r(FN_SLL, 0, 11, 12, 4), 0, FWD_RF, FWD_E, ALU_SLL, 0, 1, WB_ALU);
        expect_tag(12, 1);
        add_row("zero_src", enc_r(FN_ADD, 0, 0, 13, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 1, WB_ALU);
        expect_tag(13, 1);
        // writing $0 leaves an invalid tag
        add_row("write_zero", enc_r(FN_ADD, 13, 12, 0, 0), 0, FWD_E, FWD_M, ALU_ADD, 0, 1, WB_ALU);
        add_row("beq_zero", enc_i(OPC_BEQ, 0, 0, 2), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("bltzal", enc_i(OPC_BLTZAL, 13, 0, 2), 0, FWD_W, FWD_RF, ALU_ADD, 0, 1, WB_PC8);
        expect_tag(31, 0);
        // unknown words read nothing and never stall
        add_row("unknown_opc", enc_i(6'b111111, 31, 31, 0), 0, FWD_E, FWD_E, ALU_ADD, 0, 0, WB_ALU);
        add_row("unknown_fn", enc_r(6'b101010, 1, 2, 3, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("jump", enc_j(OPC_J, 0), 0, FWD_RF, FWD_RF, ALU_ADD, 0, 0, WB_ALU);
        add_row("subu", enc_r(FN_SUBU, 1, 2, 14, 0), 0, FWD_RF, FWD_RF, ALU_SUB, 0, 1, WB_ALU);
        expect_tag(14, 1);
        add_row("bltzal_early", enc_i(OPC_BLTZAL, 14, 0, 2), 1, FWD_E, FWD_RF, ALU_ADD, 0, 1, WB_PC8);
        expect_tag(31, 0);
        add_row("bltzal_go", enc_i(OPC_BLTZAL, 14, 0, 2), 0, FWD_M, FWD_RF, ALU_ADD, 0, 1, WB_PC8);
        expect_tag(31, 0);
        add_idle("idle_end");
        timeout_limit = rows.size() * 4 + 40;
    endtask

    task automatic check_row(input int idx);
        row_t  exp;
        string name;
        exp  = rows[idx];
        name = row_names[idx];
        assert (stall === exp.stall) else report_mismatch(name, "stall", exp.stall, stall);
        assert (issue === (exp.valid && !exp.stall))
            else report_mismatch(name, "issue", exp.valid && !exp.stall, issue);
        // ctrl and forwarding only matter for a presented word
        if (exp.valid) begin
            assert (fwd_rs === exp.fwd_rs) else report_mismatch(name, "fwd_rs", exp.fwd_rs, fwd_rs);
            assert (fwd_rt === exp.fwd_rt) else report_mismatch(name, "fwd_rt", exp.fwd_rt, fwd_rt);
            assert (ctrl.alu_op === exp.alu_op)
                else report_mismatch(name, "alu_op", exp.alu_op, ctrl.alu_op);
            assert (ctrl.mem_we === exp.mem_we)
                else report_mismatch(name, "mem_we", exp.mem_we, ctrl.mem_we);
            assert (ctrl.reg_we === exp.reg_we)
                else report_mismatch(name, "reg_we", exp.reg_we, ctrl.reg_we);
            assert (ctrl.wb_src === exp.wb_src)
                else report_mismatch(name, "wb_src", exp.wb_src, ctrl.wb_src);
            assert (dst === exp.dst) else report_mismatch(name, "dst", exp.dst, dst);
            // tnew means nothing without a destination
            if (exp.dst != '0) begin
                assert (tnew === exp.tnew) else report_mismatch(name, "tnew", exp.tnew, tnew);
            end
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("run did not finish within %0d cycles", timeout_limit);
            stop_with_failure("timeout");
        end
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'h0;
        build_table();
        repeat (RESET_TICKS) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            // a stalled word must be held by the next row
            if (i > 0 && rows[i - 1].stall) begin
                assert (rows[i].valid && rows[i].word == rows[i - 1].word)
                    else stop_with_failure("table drops a stalled instruction");
            end
            @(negedge clk);
            instr_valid = rows[i].valid;
            instr       = rows[i].word;
            // settle ahead of the rising edge
            #(CLK_PERIOD / 4);
            check_row(i);
        end

        @(negedge clk);
        instr_valid = 1'b0;
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure("checks failed");
        end
    end

endmodule
